// ==== flist.f ====
logic/dma_arb_pkg.sv
logic/seq_queue.sv
logic/dma_region_arbiter.sv
logic/dma_read_engine.sv
logic/dma_data_router.sv
logic/dma_arb_top.sv
verif/dma_arb_tb.sv

// ==== Bender.yml ====
package:
  name: dma_arb

sources:
  - files:
      - logic/dma_arb_pkg.sv
      - logic/seq_queue.sv
      - logic/dma_region_arbiter.sv
      - logic/dma_read_engine.sv
      - logic/dma_data_router.sv
      - logic/dma_arb_top.sv
  - target: test
    files:
      - verif/dma_arb_tb.sv

// ==== verif/dma_arb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_arb_tb;

  // Worst case beats and requests over all tests
  localparam int max_beats = 18 + 24 + 36 + 40 * 32;
  localparam int max_reqs = 4 + 12 + 8 + 40;
  localparam int watchdog_cycles = max_beats + 8 * max_reqs + 400;

  logic aclk;
  logic aresetn;
  logic [dma_arb_pkg::N_REGIONS-1:0] req_valid;
  logic [dma_arb_pkg::N_REGIONS-1:0] req_ready;
  logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::VADDR_BITS-1:0] req_vaddr;
  logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::LEN_BITS-1:0] req_len;
  logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::PID_BITS-1:0] req_pid;
  logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::DEST_BITS-1:0] req_dest;
  logic [dma_arb_pkg::N_REGIONS-1:0] req_stream;
  logic [dma_arb_pkg::N_REGIONS-1:0] req_host;
  logic [dma_arb_pkg::N_REGIONS-1:0] req_ctl;
  logic [dma_arb_pkg::N_REGIONS-1:0] rd_valid;
  logic [dma_arb_pkg::N_REGIONS-1:0] rd_last;
  logic [dma_arb_pkg::DATA_BITS-1:0] rd_data;
  logic [dma_arb_pkg::N_REGIONS-1:0] done;
  logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::PID_BITS-1:0] done_pid;
  logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::DEST_BITS-1:0] done_dest;
  logic [dma_arb_pkg::N_REGIONS-1:0] done_stream;
  logic [dma_arb_pkg::N_REGIONS-1:0] done_host;

  // Request word {region, ctl, host, stream, dest, pid, len, addr}
  logic [63:0] pend [$];
  logic [63:0] grants [$];
  // Beat record {region, last, data}
  logic [66:0] beats [$];
  // Done record {region, host, stream, dest, pid}
  logic [13:0] dones [$];

  logic [63:0] cur [4];
  logic [3:0] active;
  logic [3:0] hs;
  int scan [4];
  int rr_model;
  int errors = 0;
  int mon_errors = 0;
  int n_tests = 0;
  int n_failed = 0;
  int test_err0;
  int g0;
  int b0;
  int d0;
  int exp_beats;
  int exp_dones;
  int n_reqs;

  dma_arb_top uut (
    .aclk(aclk), .aresetn(aresetn),
    .req_valid(req_valid), .req_ready(req_ready), .req_vaddr(req_vaddr),
    .req_len(req_len), .req_pid(req_pid), .req_dest(req_dest),
    .req_stream(req_stream), .req_host(req_host), .req_ctl(req_ctl),
    .rd_valid(rd_valid), .rd_last(rd_last), .rd_data(rd_data),
    .done(done), .done_pid(done_pid), .done_dest(done_dest),
    .done_stream(done_stream), .done_host(done_host)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  initial begin
    #(watchdog_cycles * 10);
    $display("watchdog expired before the tests finished");
    $display(">>> FAIL");
    $finish;
  end

  // --------------------------------------------------
  // Region drivers, one request per region at a time
  // --------------------------------------------------
  initial begin
    int idx;
    req_valid = '0;
    req_vaddr = '0;
    req_len = '0;
    req_pid = '0;
    req_dest = '0;
    req_stream = '0;
    req_host = '0;
    req_ctl = '0;
    active = '0;
    for (int r = 0; r < 4; r++) begin
      scan[r] = 0;
      cur[r] = '0;
    end
    forever begin
      @(posedge aclk);
      #1;
      for (int r = 0; r < 4; r++) begin
        // Handshake at this edge frees the slot
        if (hs[r]) begin
          active[r] = 1'b0;
        end
        if (!active[r]) begin
          idx = -1;
          for (int i = scan[r]; i < pend.size(); i++) begin
            if (idx < 0 && pend[i][62:61] == r) begin
              idx = i;
            end
          end
          if (idx >= 0) begin
            cur[r] = pend[idx];
            scan[r] = idx + 1;
            active[r] = 1'b1;
          end
        end
        req_valid[r] = active[r];
        req_vaddr[r] = cur[r][31:0];
        req_len[r] = cur[r][47:32];
        req_pid[r] = cur[r][53:48];
        req_dest[r] = cur[r][57:54];
        req_stream[r] = cur[r][58];
        req_host[r] = cur[r][59];
        req_ctl[r] = cur[r][60];
      end
    end
  end

  // --------------------------------------------------
  // Monitor, sampled mid-cycle
  // --------------------------------------------------
  initial begin
    int exp_r;
    int idx;
    hs = '0;
    rr_model = 0;
    forever begin
      @(negedge aclk);
      hs = req_valid & req_ready;
      if (!aresetn) begin
        rr_model = 0;
      end else begin
        for (int r = 0; r < 4; r++) begin
          if (hs[r]) begin
            // First valid region at or after the model pointer
            exp_r = -1;
            for (int i = 0; i < 4; i++) begin
              idx = (rr_model + i) % 4;
              if (exp_r < 0 && req_valid[idx]) begin
                exp_r = idx;
              end
            end
            if (exp_r != r) begin
              $display("error at %0t: req_ready is region %0d, expected region %0d",
                       $time, r, exp_r);
              mon_errors++;
            end
            grants.push_back(cur[r]);
            rr_model = (rr_model + 1) % 4;
          end
          if (rd_valid[r]) begin
            beats.push_back({2'(r), rd_last[r], rd_data});
          end
          if (done[r]) begin
            dones.push_back({2'(r), done_host[r], done_stream[r], done_dest[r], done_pid[r]});
          end
        end
      end
    end
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic start_test();
    @(posedge aclk);
    test_err0 = errors + mon_errors;
    g0 = grants.size();
    b0 = beats.size();
    d0 = dones.size();
    exp_beats = 0;
    exp_dones = 0;
    n_reqs = 0;
    // Clear of driver and monitor slots
    #2;
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = errors + mon_errors - test_err0;
    n_tests++;
    if (errs == 0) begin
      $display("test %s passed", name);
    end else begin
      n_failed++;
      $display("test %s failed with %0d errors", name, errs);
    end
  endtask

  task automatic add_req(input int region, input logic [31:0] addr, input int len,
                         input logic [5:0] pid, input logic [3:0] dest,
                         input logic stream, input logic host, input logic ctl);
    logic [63:0] w;
    w = '0;
    w[31:0] = addr;
    w[47:32] = 16'(len);
    w[53:48] = pid;
    w[57:54] = dest;
    w[58] = stream;
    w[59] = host;
    w[60] = ctl;
    w[62:61] = 2'(region);
    pend.push_back(w);
    n_reqs++;
    // Eight bytes per beat, partial beat rounds up
    exp_beats += ((len - 1) >> 3) + 1;
    if (ctl) begin
      exp_dones++;
    end
  endtask

  // Until every grant, beat and done of the test has shown up
  task automatic wait_drained();
    int limit;
    int cyc;
    limit = exp_beats + 8 * n_reqs + 40;
    cyc = 0;
    while (cyc < limit && !(grants.size() - g0 >= n_reqs && beats.size() - b0 >= exp_beats
           && dones.size() - d0 >= exp_dones)) begin
      @(posedge aclk);
      cyc++;
    end
    if (cyc >= limit) begin
      $display("timed out at %0t waiting for grants, beats or done pulses", $time);
      errors++;
    end
    // A few idle cycles expose stray outputs
    repeat (4) @(posedge aclk);
  endtask

  // Per region beats in grant order, then completions in grant order
  task automatic check_traffic();
    logic [63:0] g;
    logic [63:0] base;
    int bi;
    int di;
    int nb;
    for (int r = 0; r < 4; r++) begin
      bi = b0;
      for (int gi = g0; gi < grants.size(); gi++) begin
        g = grants[gi];
        if (g[62:61] == r) begin
          nb = ((int'(g[47:32]) - 1) >> 3) + 1;
          base = {32'h0, g[31:3], 3'b000};
          for (int k = 0; k < nb; k++) begin
            while (bi < beats.size() && beats[bi][66:65] != r) bi++;
            if (bi >= beats.size()) begin
              $display("region %0d is missing beat %0d of a %0d-beat read", r, k, nb);
              errors++;
              break;
            end
            compare("rd_data", beats[bi][63:0], base + 8 * k);
            compare("rd_last", beats[bi][64], k == nb - 1);
            bi++;
          end
        end
      end
      while (bi < beats.size() && beats[bi][66:65] != r) bi++;
      if (bi < beats.size()) begin
        $display("region %0d received more beats than it requested", r);
        errors++;
      end
    end
    di = d0;
    for (int gi = g0; gi < grants.size(); gi++) begin
      g = grants[gi];
      if (g[60]) begin
        if (di >= dones.size()) begin
          $display("done pulse missing for a ctl request of region %0d", g[62:61]);
          errors++;
        end else begin
          compare("done region", dones[di][13:12], g[62:61]);
          compare("done_host", dones[di][11], g[59]);
          compare("done_stream", dones[di][10], g[58]);
          compare("done_dest", dones[di][9:6], g[57:54]);
          compare("done_pid", dones[di][5:0], g[53:48]);
        end
        di++;
      end
    end
    if (di < dones.size()) begin
      $display("more done pulses than ctl requests");
      errors++;
    end
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic test_reset();
    start_test();
    repeat (3) begin
      @(negedge aclk);
      compare("req_ready", req_ready, 0);
      compare("rd_valid", rd_valid, 0);
      compare("rd_last", rd_last, 0);
      compare("done", done, 0);
    end
    finish_test("reset");
  endtask

  task automatic test_single();
    start_test();
    for (int r = 0; r < 4; r++) begin
      add_req(r, 32'h1000 * (r + 1) + 5 * r, 20 + 8 * r, 6'(r + 1), 4'(r + 2), r[0], ~r[0], 1'b1);
      wait_drained();
    end
    check_traffic();
    finish_test("single");
  endtask

  task automatic test_round_robin();
    int p0;
    start_test();
    p0 = rr_model;
    for (int k = 0; k < 3; k++) begin
      for (int r = 0; r < 4; r++) begin
        add_req(r, 32'h4000 + 32'h40 * k + 32'h400 * r, 16, 6'(k), 4'(r), 1'b0, 1'b1, 1'b1);
      end
    end
    wait_drained();
    // All four held valid, so the grants walk the pointer
    for (int k = 0; k < 12 && g0 + k < grants.size(); k++) begin
      compare("grant region", grants[g0 + k][62:61], (p0 + k) % 4);
    end
    check_traffic();
    finish_test("round_robin");
  endtask

  task automatic test_ctl_mix();
    start_test();
    for (int i = 0; i < 8; i++) begin
      add_req(3 - i % 4, 32'h2000 + 32'h100 * i + i, 8 * (i + 1), 6'(10 + i), 4'(i),
              i[1], i[0], (i % 3) != 1);
    end
    wait_drained();
    check_traffic();
    finish_test("ctl_mix");
  endtask

  task automatic test_random();
    int region;
    int len;
    logic [31:0] rnd;
    start_test();
    for (int i = 0; i < 40; i++) begin
      region = $urandom % 4;
      len = $urandom_range(256, 1);
      rnd = $urandom;
      add_req(region, $urandom & 32'h00ff_ffff, len, rnd[5:0], rnd[9:6],
              rnd[10], rnd[11], rnd[12]);
    end
    wait_drained();
    check_traffic();
    compare("done count", dones.size() - d0, exp_dones);
    finish_test("random");
  endtask

  initial begin
    int total;
    void'($urandom(32656));
    aresetn = 1'b0;
    repeat (2) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    test_reset();
    test_single();
    test_round_robin();
    test_ctl_mix();
    test_random();
    total = errors + mon_errors;
    $display("tests run %0d, tests failed %0d, errors %0d", n_tests, n_failed, total);
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/dma_arb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_arb_top (
  input  logic aclk,
  input  logic aresetn,

  // Region requests
  input  logic [dma_arb_pkg::N_REGIONS-1:0] req_valid,
  output logic [dma_arb_pkg::N_REGIONS-1:0] req_ready,
  input  logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::VADDR_BITS-1:0] req_vaddr,
  input  logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::LEN_BITS-1:0] req_len,
  input  logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::PID_BITS-1:0] req_pid,
  input  logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::DEST_BITS-1:0] req_dest,
  input  logic [dma_arb_pkg::N_REGIONS-1:0] req_stream,
  input  logic [dma_arb_pkg::N_REGIONS-1:0] req_host,
  input  logic [dma_arb_pkg::N_REGIONS-1:0] req_ctl,

  // Read data
  output logic [dma_arb_pkg::N_REGIONS-1:0] rd_valid,
  output logic [dma_arb_pkg::N_REGIONS-1:0] rd_last,
  output logic [dma_arb_pkg::DATA_BITS-1:0] rd_data,

  // Completions
  output logic [dma_arb_pkg::N_REGIONS-1:0] done,
  output logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::PID_BITS-1:0] done_pid,
  output logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::DEST_BITS-1:0] done_dest,
  output logic [dma_arb_pkg::N_REGIONS-1:0] done_stream,
  output logic [dma_arb_pkg::N_REGIONS-1:0] done_host
);

  // Arbiter to engine
  logic eng_req_valid;
  logic eng_req_ready;
  logic [dma_arb_pkg::VADDR_BITS-1:0] eng_vaddr;
  logic [dma_arb_pkg::LEN_BITS-1:0] eng_len;
  logic eng_ctl;
  logic eng_done;

  // Arbiter to router
  logic seq_valid;
  logic seq_ready;
  logic [dma_arb_pkg::N_REGIONS_BITS-1:0] seq_region;
  logic [dma_arb_pkg::BLEN_BITS-1:0] seq_beats;

  // Engine to router
  logic beat_valid;
  logic beat_ready;
  logic [dma_arb_pkg::DATA_BITS-1:0] beat_data;

  dma_region_arbiter u_arbiter (
    .aclk(aclk),
    .aresetn(aresetn),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .req_vaddr(req_vaddr),
    .req_len(req_len),
    .req_pid(req_pid),
    .req_dest(req_dest),
    .req_stream(req_stream),
    .req_host(req_host),
    .req_ctl(req_ctl),
    .eng_req_valid(eng_req_valid),
    .eng_req_ready(eng_req_ready),
    .eng_vaddr(eng_vaddr),
    .eng_len(eng_len),
    .eng_ctl(eng_ctl),
    .eng_done(eng_done),
    .seq_valid(seq_valid),
    .seq_ready(seq_ready),
    .seq_region(seq_region),
    .seq_beats(seq_beats),
    .done(done),
    .done_pid(done_pid),
    .done_dest(done_dest),
    .done_stream(done_stream),
    .done_host(done_host)
  );

  dma_read_engine u_engine (
    .aclk(aclk),
    .aresetn(aresetn),
    .eng_req_valid(eng_req_valid),
    .eng_req_ready(eng_req_ready),
    .eng_vaddr(eng_vaddr),
    .eng_len(eng_len),
    .eng_ctl(eng_ctl),
    .eng_done(eng_done),
    .beat_valid(beat_valid),
    .beat_ready(beat_ready),
    .beat_data(beat_data)
  );

  dma_data_router u_router (
    .aclk(aclk),
    .aresetn(aresetn),
    .seq_valid(seq_valid),
    .seq_ready(seq_ready),
    .seq_region(seq_region),
    .seq_beats(seq_beats),
    .beat_valid(beat_valid),
    .beat_ready(beat_ready),
    .beat_data(beat_data),
    .rd_valid(rd_valid),
    .rd_last(rd_last),
    .rd_data(rd_data)
  );

endmodule

`default_nettype wire

// ==== logic/dma_data_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_data_router (
  input  logic aclk,
  input  logic aresetn,

  // Routing sequence
  input  logic seq_valid,
  output logic seq_ready,
  input  logic [dma_arb_pkg::N_REGIONS_BITS-1:0] seq_region,
  input  logic [dma_arb_pkg::BLEN_BITS-1:0] seq_beats,

  // Engine beats
  input  logic beat_valid,
  output logic beat_ready,
  input  logic [dma_arb_pkg::DATA_BITS-1:0] beat_data,

  // Region data
  output logic [dma_arb_pkg::N_REGIONS-1:0] rd_valid,
  output logic [dma_arb_pkg::N_REGIONS-1:0] rd_last,
  output logic [dma_arb_pkg::DATA_BITS-1:0] rd_data
);

  logic [dma_arb_pkg::BLEN_BITS-1:0] cnt;
  logic xfer;
  logic is_last;

  // Beats only flow once the owner is known
  assign beat_ready = seq_valid;
  assign xfer = beat_valid && beat_ready;
  assign is_last = (cnt == seq_beats);

  // Final beat retires the routing entry
  assign seq_ready = xfer && is_last;

  // --------------------------------------------------
  // Beat counter and steering
  // --------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      cnt <= '0;
      rd_valid <= '0;
      rd_last <= '0;
    end else begin
      rd_valid <= '0;
      rd_last <= '0;
      if (xfer) begin
        rd_valid[seq_region] <= 1'b1;
        rd_last[seq_region] <= is_last;
        cnt <= is_last ? '0 : cnt + 1'b1;
      end
    end
  end

  // Shared data bus
  always_ff @(posedge aclk) begin
    if (xfer) begin
      rd_data <= beat_data;
    end
  end

  a_rd_onehot: assert property (@(posedge aclk) disable iff (!aresetn)
    $onehot0(rd_valid) && ((rd_last & ~rd_valid) == '0));

endmodule

`default_nettype wire

// ==== logic/dma_read_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_read_engine (
  input  logic aclk,
  input  logic aresetn,

  // Granted request
  input  logic eng_req_valid,
  output logic eng_req_ready,
  input  logic [dma_arb_pkg::VADDR_BITS-1:0] eng_vaddr,
  input  logic [dma_arb_pkg::LEN_BITS-1:0] eng_len,
  input  logic eng_ctl,
  output logic eng_done,

  // Beat stream
  output logic beat_valid,
  input  logic beat_ready,
  output logic [dma_arb_pkg::DATA_BITS-1:0] beat_data
);

  logic busy;
  logic ctl_q;
  logic accept;
  logic last_xfer;
  logic [dma_arb_pkg::LEN_BITS-1:0] len_m1;
  // Word address with the low byte bits dropped
  logic [dma_arb_pkg::VADDR_BITS-dma_arb_pkg::BEAT_LOG_BITS-1:0] waddr;
  logic [dma_arb_pkg::BLEN_BITS-1:0] rem;

  assign eng_req_ready = !busy;
  assign accept = eng_req_valid && eng_req_ready;
  assign len_m1 = eng_len - 1'b1;

  assign beat_valid = busy;
  assign last_xfer = beat_valid && beat_ready && (rem == '0);

  // Host memory model where each word holds its own aligned address
  assign beat_data = {{(dma_arb_pkg::DATA_BITS - dma_arb_pkg::VADDR_BITS){1'b0}},
                      waddr, {dma_arb_pkg::BEAT_LOG_BITS{1'b0}}};

  // --------------------------------------------------
  // Burst control
  // --------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      busy <= 1'b0;
      ctl_q <= 1'b0;
      rem <= '0;
      eng_done <= 1'b0;
    end else begin
      // Done one cycle after the final beat of a ctl request
      eng_done <= last_xfer && ctl_q;
      if (accept) begin
        busy <= 1'b1;
        ctl_q <= eng_ctl;
        rem <= len_m1[dma_arb_pkg::LEN_BITS-1:dma_arb_pkg::BEAT_LOG_BITS];
      end else if (beat_valid && beat_ready) begin
        if (rem == '0) begin
          busy <= 1'b0;
        end else begin
          rem <= rem - 1'b1;
        end
      end
    end
  end

  // Word address steps once per beat
  always_ff @(posedge aclk) begin
    if (accept) begin
      waddr <= eng_vaddr[dma_arb_pkg::VADDR_BITS-1:dma_arb_pkg::BEAT_LOG_BITS];
    end else if (beat_valid && beat_ready) begin
      waddr <= waddr + 1'b1;
    end
  end

  // No new burst while beats of the last one remain
  a_no_accept_busy: assert property (@(posedge aclk) disable iff (!aresetn)
    accept |-> (rem == '0));

endmodule

`default_nettype wire

// ==== logic/dma_region_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_region_arbiter (
  input  logic aclk,
  input  logic aresetn,

  // Region requests
  input  logic [dma_arb_pkg::N_REGIONS-1:0] req_valid,
  output logic [dma_arb_pkg::N_REGIONS-1:0] req_ready,
  input  logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::VADDR_BITS-1:0] req_vaddr,
  input  logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::LEN_BITS-1:0] req_len,
  input  logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::PID_BITS-1:0] req_pid,
  input  logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::DEST_BITS-1:0] req_dest,
  input  logic [dma_arb_pkg::N_REGIONS-1:0] req_stream,
  input  logic [dma_arb_pkg::N_REGIONS-1:0] req_host,
  input  logic [dma_arb_pkg::N_REGIONS-1:0] req_ctl,

  // Read engine
  output logic eng_req_valid,
  input  logic eng_req_ready,
  output logic [dma_arb_pkg::VADDR_BITS-1:0] eng_vaddr,
  output logic [dma_arb_pkg::LEN_BITS-1:0] eng_len,
  output logic eng_ctl,
  input  logic eng_done,

  // Routing sequence to the data router
  output logic seq_valid,
  input  logic seq_ready,
  output logic [dma_arb_pkg::N_REGIONS_BITS-1:0] seq_region,
  output logic [dma_arb_pkg::BLEN_BITS-1:0] seq_beats,

  // Completions back to the regions
  output logic [dma_arb_pkg::N_REGIONS-1:0] done,
  output logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::PID_BITS-1:0] done_pid,
  output logic [dma_arb_pkg::N_REGIONS-1:0][dma_arb_pkg::DEST_BITS-1:0] done_dest,
  output logic [dma_arb_pkg::N_REGIONS-1:0] done_stream,
  output logic [dma_arb_pkg::N_REGIONS-1:0] done_host
);

  logic [dma_arb_pkg::N_REGIONS_BITS-1:0] rr_ptr;
  logic [dma_arb_pkg::N_REGIONS_BITS-1:0] cand;
  logic found;
  logic room;
  logic grant;
  logic [dma_arb_pkg::LEN_BITS-1:0] len_m1;

  logic seq_rdy_in;
  logic [dma_arb_pkg::SEQ_USER_BITS-1:0] seq_in;
  logic [dma_arb_pkg::SEQ_USER_BITS-1:0] seq_out;

  logic dq_rdy_in;
  logic dq_valid;
  logic [dma_arb_pkg::SEQ_DONE_BITS-1:0] dq_in;
  logic dq_host;
  logic dq_stream;
  logic [dma_arb_pkg::DEST_BITS-1:0] dq_dest;
  logic [dma_arb_pkg::N_REGIONS_BITS-1:0] dq_region;
  logic [dma_arb_pkg::PID_BITS-1:0] dq_pid;

  // --------------------------------------------------
  // Round-robin pointer
  // --------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rr_ptr <= '0;
    end else if (grant) begin
      // One step per grant, whoever won
      rr_ptr <= (rr_ptr == dma_arb_pkg::N_REGIONS-1) ? '0 : rr_ptr + 1'b1;
    end
  end

  // First valid region at or above the pointer, wrapping
  always_comb begin
    int idx;
    cand = '0;
    found = 1'b0;
    for (int i = 0; i < dma_arb_pkg::N_REGIONS; i++) begin
      idx = (int'(rr_ptr) + i) % dma_arb_pkg::N_REGIONS;
      if (!found && req_valid[idx]) begin
        found = 1'b1;
        cand = idx[dma_arb_pkg::N_REGIONS_BITS-1:0];
      end
    end
  end

  // Both queues need a free slot before anything goes out
  assign room = seq_rdy_in && dq_rdy_in;
  assign eng_req_valid = found && room;
  assign grant = eng_req_valid && eng_req_ready;

  always_comb begin
    req_ready = '0;
    req_ready[cand] = found && room && eng_req_ready;
  end

  assign eng_vaddr = req_vaddr[cand];
  assign eng_len = req_len[cand];
  assign eng_ctl = req_ctl[cand];

  // --------------------------------------------------
  // Sequence queues
  // --------------------------------------------------
  assign len_m1 = req_len[cand] - 1'b1;
  assign seq_in = {req_ctl[cand], cand,
                   len_m1[dma_arb_pkg::LEN_BITS-1:dma_arb_pkg::BEAT_LOG_BITS]};
  assign dq_in = {req_host[cand], req_stream[cand], req_dest[cand], cand, req_pid[cand]};

  seq_queue #(
    .QWIDTH(dma_arb_pkg::SEQ_USER_BITS),
    .QDEPTH(dma_arb_pkg::N_OUTSTANDING)
  ) u_seq_user (
    .aclk(aclk),
    .aresetn(aresetn),
    .val_snk(grant),
    .rdy_snk(seq_rdy_in),
    .data_snk(seq_in),
    .val_src(seq_valid),
    .rdy_src(seq_ready),
    .data_src(seq_out)
  );

  // Router only needs region and beat count, ctl bit stays behind
  assign seq_region = seq_out[dma_arb_pkg::BLEN_BITS +: dma_arb_pkg::N_REGIONS_BITS];
  assign seq_beats = seq_out[dma_arb_pkg::BLEN_BITS-1:0];

  // Completion entries only for ctl requests
  seq_queue #(
    .QWIDTH(dma_arb_pkg::SEQ_DONE_BITS),
    .QDEPTH(dma_arb_pkg::N_OUTSTANDING)
  ) u_seq_done (
    .aclk(aclk),
    .aresetn(aresetn),
    .val_snk(grant && req_ctl[cand]),
    .rdy_snk(dq_rdy_in),
    .data_snk(dq_in),
    .val_src(dq_valid),
    .rdy_src(eng_done),
    .data_src({dq_host, dq_stream, dq_dest, dq_region, dq_pid})
  );

  // Head entry steered to its owner
  always_comb begin
    done = '0;
    done_pid = '0;
    done_dest = '0;
    done_stream = '0;
    done_host = '0;
    done[dq_region] = eng_done;
    done_pid[dq_region] = dq_pid;
    done_dest[dq_region] = dq_dest;
    done_stream[dq_region] = dq_stream;
    done_host[dq_region] = dq_host;
  end

  a_ready_onehot: assert property (@(posedge aclk) disable iff (!aresetn)
    $onehot0(req_ready));

  // Engine completions must match a ctl grant still queued
  a_done_has_entry: assert property (@(posedge aclk) disable iff (!aresetn)
    eng_done |-> dq_valid);

endmodule

`default_nettype wire

// ==== logic/seq_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module seq_queue #(
  parameter integer QWIDTH = 16,
  parameter integer QDEPTH = 8
) (
  input  logic              aclk,
  input  logic              aresetn,

  // Write side
  input  logic              val_snk,
  output logic              rdy_snk,
  input  logic [QWIDTH-1:0] data_snk,

  // Read side
  output logic              val_src,
  input  logic              rdy_src,
  output logic [QWIDTH-1:0] data_src
);

  logic [QWIDTH-1:0] mem [QDEPTH];
  logic [$clog2(QDEPTH)-1:0] wr_ptr;
  logic [$clog2(QDEPTH)-1:0] rd_ptr;
  logic [$clog2(QDEPTH+1)-1:0] count;
  logic push;
  logic pop;

  assign rdy_snk = (count != QDEPTH);
  assign val_src = (count != 0);
  assign push = val_snk && rdy_snk;
  assign pop = val_src && rdy_src;

  // Head entry straight off the array
  assign data_src = mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= data_snk;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (int'(wr_ptr) == QDEPTH-1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == QDEPTH-1) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  a_count_bound: assert property (@(posedge aclk) disable iff (!aresetn)
    count <= QDEPTH);

endmodule

`default_nettype wire

// ==== logic/dma_arb_pkg.sv ====
`default_nettype none

package dma_arb_pkg;

  // User regions
  localparam integer N_REGIONS = 4;
  localparam integer N_REGIONS_BITS = 2;

  // Request fields
  localparam integer VADDR_BITS = 32;
  localparam integer LEN_BITS = 16;
  localparam integer PID_BITS = 6;
  localparam integer DEST_BITS = 4;

  // Data path, 8 bytes per beat
  localparam integer DATA_BITS = 64;
  localparam integer BEAT_LOG_BITS = 3;
  localparam integer BLEN_BITS = LEN_BITS - BEAT_LOG_BITS;

  // Sequence queues
  localparam integer N_OUTSTANDING = 8;
  // Routing entry {ctl, region, beats-1}
  localparam integer SEQ_USER_BITS = 1 + N_REGIONS_BITS + BLEN_BITS;
  // Completion entry {host, stream, dest, region, pid}
  localparam integer SEQ_DONE_BITS = 1 + 1 + DEST_BITS + N_REGIONS_BITS + PID_BITS;

endpackage

`default_nettype wire
